//--- build.f
lsb_pkg.sv
trig_sync.sv
pack_unpacker.sv
line_ram.sv
line_buffer.sv
line_swap_buffer.sv
cam_capture_top.sv
tb_clock.sv
tb_cam_capture.sv

//--- cam_capture_top.sv
`timescale 1ns/1ps

module cam_capture_top import lsb_pkg::*; #(
    parameter  int h_act       = 1280,
    parameter  int v_act       = 720,
    parameter  int default_cam = 1,
    localparam int ROW_W       = $clog2(v_act),
    localparam int PACK_W      = PIX_W + FLAG_W + $clog2(h_act) + ROW_W
) (
    input  logic              rclk,
    input  logic              rstn,
    input  logic              trig,
    input  logic [PACK_W-1:0] cam1_pack,
    input  logic [PACK_W-1:0] cam2_pack,
    output logic              aquire,
    input  logic              read_en,
    output logic [7:0]        cam_data,
    output logic [ROW_W-1:0]  cam_row,
    output logic              cam_id,
    output logic [3:0]        cnt,
    output logic              busy,
    output logic              error
);

    logic              trig_pend, trig_take;
    logic              buf_trig, buf_busy;
    logic [PACK_W-1:0] cam_pack;

    trig_sync trig_sync_inst (
        .rclk      (rclk),
        .rstn      (rstn),
        .trig      (trig),
        .trig_take (trig_take),
        .trig_pend (trig_pend)
    );

    line_swap_buffer #(
        .h_act       (h_act),
        .v_act       (v_act),
        .default_cam (default_cam)
    ) line_swap_buffer_inst (
        .rclk      (rclk),
        .rstn      (rstn),
        .trig_pend (trig_pend),
        .trig_take (trig_take),
        .cam1_pack (cam1_pack),
        .cam2_pack (cam2_pack),
        .cam_pack  (cam_pack),
        .buf_busy  (buf_busy),
        .buf_trig  (buf_trig),
        .cam_id    (cam_id),
        .cnt       (cnt),
        .busy      (busy)
    );

    line_buffer #(.h_act(h_act), .v_act(v_act)) line_buffer_inst (
        .rclk     (rclk),
        .rstn     (rstn),
        .cam_pack (cam_pack),
        .trig     (buf_trig),
        .aquire   (aquire),
        .read_en  (read_en),
        .cam_data (cam_data),
        .cam_row  (cam_row),
        .busy     (buf_busy),
        .error    (error)
    );

endmodule : cam_capture_top

//--- line_buffer.sv
`timescale 1ns/1ps

module line_buffer import lsb_pkg::*; #(
    parameter  int h_act  = 1280,
    parameter  int v_act  = 720,
    localparam int COL_W  = $clog2(h_act),
    localparam int ROW_W  = $clog2(v_act),
    localparam int PACK_W = PIX_W + FLAG_W + COL_W + ROW_W
) (
    input  logic              rclk,
    input  logic              rstn,
    input  logic [PACK_W-1:0] cam_pack,
    input  logic              trig,
    output logic              aquire,
    input  logic              read_en,
    output logic [7:0]        cam_data,
    output logic [ROW_W-1:0]  cam_row,
    output logic              busy,
    output logic              error
);

    localparam int NPACK = h_act / PIX_BYTES;
    localparam int IDX_W = (NPACK > 1) ? $clog2(NPACK) : 1;

    buf_state_t       state;
    logic [IDX_W-1:0] pack_cnt;
    logic [IDX_W-1:0] rd_word, hold_word, raddr;
    logic [1:0]       rd_lane, sel_q;
    logic [PIX_W-1:0] pix;
    logic             valid, take, rd_fire;
    logic [7:0]       lane_rdata [PIX_BYTES];

    assign take     = (state == B_TAKE);
    assign rd_fire  = (state == B_DRAIN) && read_en;
    assign raddr    = rd_fire ? rd_word : hold_word;   // hold last word between reads.
    assign busy     = (state != B_IDLE);
    assign cam_data = lane_rdata[sel_q];

    pack_unpacker #(.h_act(h_act), .v_act(v_act)) pack_unpacker_inst (
        .pack     (cam_pack),
        .pack_idx (pack_cnt),
        .first    (pack_cnt == '0),
        .take     (take),
        .rclk     (rclk),
        .rstn     (rstn),
        .pix      (pix),
        .valid    (valid),
        .row      (cam_row),
        .err      (error)
    );

    // one lane per pixel byte, all written with the pack.
    for (genvar i = 0; i < PIX_BYTES; i++) begin : g_lane
        line_ram #(.depth(NPACK)) line_ram_inst (
            .rclk  (rclk),
            .we    (take && valid),
            .waddr (pack_cnt),
            .wdata (pix[i*8 +: 8]),
            .raddr (raddr),
            .rdata (lane_rdata[i])
        );
    end

    always_ff @(posedge rclk or negedge rstn) begin
        if (!rstn) begin
            state     <= B_IDLE;
            aquire    <= 1'b0;
            pack_cnt  <= '0;
            rd_word   <= '0;
            rd_lane   <= '0;
            hold_word <= '0;
            sel_q     <= '0;
        end else begin
            aquire <= 1'b0;
            case (state)
                B_IDLE: begin
                    if (trig) begin
                        state    <= B_REQ;
                        aquire   <= 1'b1;
                        pack_cnt <= '0;
                        rd_word  <= '0;
                        rd_lane  <= '0;
                    end
                end
                B_REQ: state <= B_TAKE;
                B_TAKE: begin
                    if (!valid) begin
                        state  <= B_REQ;     // ask again, count nothing.
                        aquire <= 1'b1;
                    end else if (pack_cnt == IDX_W'(NPACK - 1)) begin
                        state <= B_DRAIN;
                    end else begin
                        pack_cnt <= pack_cnt + 1'b1;
                        state    <= B_REQ;
                        aquire   <= 1'b1;
                    end
                end
                B_DRAIN: begin
                    if (read_en) begin
                        hold_word <= rd_word;
                        sel_q     <= rd_lane;
                        if (rd_lane == 2'(PIX_BYTES - 1)) begin
                            rd_lane <= '0;
                            if (rd_word == IDX_W'(NPACK - 1)) begin
                                state <= B_IDLE;   // last byte out.
                            end else begin
                                rd_word <= rd_word + 1'b1;
                            end
                        end else begin
                            rd_lane <= rd_lane + 1'b1;
                        end
                    end
                end
            endcase
        end
    end

    a_aquire_req: assert property (@(posedge rclk) disable iff (!rstn)
        aquire |-> state == B_REQ)
        else $error("aquire outside B_REQ");

endmodule : line_buffer

//--- line_ram.sv
`timescale 1ns/1ps

module line_ram #(
    parameter  int depth = 426,
    localparam int AW    = (depth > 1) ? $clog2(depth) : 1
) (
    input  logic          rclk,
    input  logic          we,
    input  logic [AW-1:0] waddr,
    input  logic [7:0]    wdata,
    input  logic [AW-1:0] raddr,
    output logic [7:0]    rdata
);

    logic [7:0] mem [depth];

    always_ff @(posedge rclk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // registered read.
    always_ff @(posedge rclk) begin
        rdata <= mem[raddr];
    end

endmodule : line_ram

//--- line_swap_buffer.sv
`timescale 1ns/1ps

module line_swap_buffer import lsb_pkg::*; #(
    parameter  int h_act       = 1280,
    parameter  int v_act       = 720,
    parameter  int default_cam = 1,
    localparam int PACK_W      = PIX_W + FLAG_W + $clog2(h_act) + $clog2(v_act)
) (
    input  logic              rclk,
    input  logic              rstn,
    input  logic              trig_pend,
    output logic              trig_take,
    input  logic [PACK_W-1:0] cam1_pack,
    input  logic [PACK_W-1:0] cam2_pack,
    output logic [PACK_W-1:0] cam_pack,
    input  logic              buf_busy,
    output logic              buf_trig,
    output logic              cam_id,
    output logic [3:0]        cnt,
    output logic              busy
);

    localparam int GAP_W = $clog2(h_act + 1);

    seq_state_t       state;
    logic [GAP_W-1:0] gap_cnt;

    assign cam_pack  = (cam_id == 1'(default_cam)) ? cam1_pack : cam2_pack;
    assign busy      = (state != IDLE);
    assign trig_take = (state == IDLE) && trig_pend;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // two-camera sequence
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge rclk or negedge rstn) begin
        if (!rstn) begin
            state    <= IDLE;
            cnt      <= '0;
            cam_id   <= 1'b0;
            buf_trig <= 1'b0;
            gap_cnt  <= '0;
        end else begin
            case (state)
                IDLE: begin
                    cam_id   <= 1'b0;
                    buf_trig <= 1'b0;
                    gap_cnt  <= '0;
                    if (trig_pend) begin
                        cnt   <= cnt + 1'b1;   // wraps after 15.
                        state <= TRIG_CAM1;
                    end
                end
                TRIG_CAM1, TRIG_CAM2: begin
                    if (buf_busy) begin
                        buf_trig <= 1'b0;
                        state    <= (state == TRIG_CAM1) ? WAIT_CAM1 : WAIT_CAM2;
                    end else begin
                        buf_trig <= 1'b1;
                    end
                end
                WAIT_CAM1: begin
                    if (!buf_busy) begin
                        gap_cnt <= '0;
                        state   <= GAP;
                    end
                end
                GAP: begin
                    if (gap_cnt != GAP_W'(h_act)) begin
                        gap_cnt <= gap_cnt + 1'b1;
                    end else begin
                        cam_id <= 1'b1;           // second camera.
                        state  <= TRIG_CAM2;
                    end
                end
                WAIT_CAM2: begin
                    if (!buf_busy) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    a_state_legal: assert property (@(posedge rclk) disable iff (!rstn)
        state inside {IDLE, TRIG_CAM1, WAIT_CAM1, GAP, TRIG_CAM2, WAIT_CAM2})
        else $error("illegal sequencer state");

    a_trig_in_trig: assert property (@(posedge rclk) disable iff (!rstn)
        buf_trig |-> state inside {TRIG_CAM1, TRIG_CAM2})
        else $error("buf_trig outside a trigger state");

endmodule : line_swap_buffer

//--- lsb_pkg.sv
package lsb_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // sequencer and buffer states
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef enum logic [2:0] {
        IDLE      = 3'd0,
        TRIG_CAM1 = 3'd1,
        WAIT_CAM1 = 3'd2,
        GAP       = 3'd3,
        TRIG_CAM2 = 3'd4,
        WAIT_CAM2 = 3'd5
    } seq_state_t;

    typedef enum logic [1:0] {
        B_IDLE  = 2'd0,
        B_REQ   = 2'd1,
        B_TAKE  = 2'd2,
        B_DRAIN = 2'd3
    } buf_state_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // pack layout, lsb first
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int PIX_BYTES  = 3;
    localparam int PIX_W      = PIX_BYTES * 8;
    localparam int FLAG_W     = 4;
    localparam int FLAG_VALID = 0;             // others reserved.
    localparam int FLAG_LSB   = PIX_W;
    localparam int COL_LSB    = PIX_W + FLAG_W; // row follows column.

endpackage : lsb_pkg

//--- pack_unpacker.sv
`timescale 1ns/1ps

module pack_unpacker import lsb_pkg::*; #(
    parameter  int h_act  = 1280,
    parameter  int v_act  = 720,
    localparam int COL_W  = $clog2(h_act),
    localparam int ROW_W  = $clog2(v_act),
    localparam int PACK_W = PIX_W + FLAG_W + COL_W + ROW_W,
    localparam int NPACK  = h_act / PIX_BYTES,
    localparam int IDX_W  = (NPACK > 1) ? $clog2(NPACK) : 1
) (
    input  logic [PACK_W-1:0] pack,
    input  logic [IDX_W-1:0]  pack_idx,
    input  logic              first,
    input  logic              take,
    input  logic              rclk,
    input  logic              rstn,
    output logic [PIX_W-1:0]  pix,
    output logic              valid,
    output logic [ROW_W-1:0]  row,
    output logic              err
);

    localparam int ROW_LSB = COL_LSB + COL_W;

    logic [COL_W-1:0] col_in;
    logic [ROW_W-1:0] row_in;
    logic [COL_W-1:0] exp_col;
    logic             bad;

    assign pix     = pack[PIX_W-1:0];
    assign valid   = pack[FLAG_LSB + FLAG_VALID];
    assign col_in  = pack[COL_LSB +: COL_W];
    assign row_in  = pack[ROW_LSB +: ROW_W];
    assign exp_col = COL_W'(pack_idx) * COL_W'(PIX_BYTES);

    // first pack defines the row, so only its column is checked.
    assign bad = (col_in != exp_col) || (!first && (row_in != row));

    always_ff @(posedge rclk) begin
        if (take && valid && first) begin
            row <= row_in;
        end
    end

    always_ff @(posedge rclk or negedge rstn) begin
        if (!rstn) begin
            err <= 1'b0;
        end else if (take && valid && bad) begin
            err <= 1'b1;                 // sticky.
        end
    end

endmodule : pack_unpacker

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

LOG=sim.log
rm -rf obj_dir "$LOG"

verilator --binary --timing --assert -j 0 --top-module tb_cam_capture -f build.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vtb_cam_capture > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^TEST OK$" "$LOG"; then
    echo "simulation passed"
    exit 0
fi
echo "pass line not found in $LOG"
exit 1

//--- tb_cam_capture.sv
`timescale 1ns/1ps

module tb_cam_capture;

    localparam int H_ACT    = 24;
    localparam int V_ACT    = 16;
    localparam int COL_W    = $clog2(H_ACT);
    localparam int ROW_W    = $clog2(V_ACT);
    localparam int FLAG_LSB = 24;           // flags sit right above the pixel bytes.
    localparam int PACK_W   = 24 + 4 + COL_W + ROW_W;
    localparam int NPACK    = H_ACT / 3;

    logic              rclk, rstn, rst_req;
    logic              trig, read_en, aquire;
    logic [PACK_W-1:0] cam1_pack, cam2_pack;
    logic [7:0]        cam_data;
    logic [ROW_W-1:0]  cam_row;
    logic              cam_id, busy, error;
    logic [3:0]        cnt;

    // camera and reader models, index 0 is camera 1.
    logic [7:0]        line_bytes [2][H_ACT];
    logic [ROW_W-1:0]  line_row [2];
    int                pk_idx [2];
    logic [7:0]        exp_byte_q [$];
    logic [ROW_W-1:0]  exp_row_q [$];
    int                lines_filled;
    int                rd_left;
    bit                chk_pending;
    bit                busy_q;
    bit                bad_col_once;
    logic [3:0]        exp_cnt;
    int unsigned       seed_val;

    tb_clock tb_clock_inst (
        .rst_req (rst_req),
        .rclk    (rclk),
        .rstn    (rstn)
    );

    cam_capture_top #(
        .h_act       (H_ACT),
        .v_act       (V_ACT),
        .default_cam (1)
    ) cam_capture_top_inst (
        .rclk      (rclk),
        .rstn      (rstn),
        .trig      (trig),
        .cam1_pack (cam1_pack),
        .cam2_pack (cam2_pack),
        .aquire    (aquire),
        .read_en   (read_en),
        .cam_data  (cam_data),
        .cam_row   (cam_row),
        .cam_id    (cam_id),
        .cnt       (cnt),
        .busy      (busy),
        .error     (error)
    );

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("TEST FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_val(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
        if (expected !== actual) begin
            stop_run($sformatf("Fail %s: expected %0h, actual %0h", name, expected, actual));
        end
    endtask

    function automatic logic [PACK_W-1:0] make_pack(input logic [ROW_W-1:0] row,
            input int col, input logic [23:0] pix, input bit vld);
        return {row, COL_W'(col), 3'b000, vld, pix};
    endfunction

    // fresh line for camera c, queued in fill order.
    task automatic new_line(input int c);
        line_row[c] = ROW_W'($urandom);
        for (int i = 0; i < H_ACT; i++) begin
            line_bytes[c][i] = 8'($urandom);
            exp_byte_q.push_back(line_bytes[c][i]);
        end
        exp_row_q.push_back(line_row[c]);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // per-cycle models
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic serve_camera();
        int                c;
        int                base;
        int                col;
        logic [PACK_W-1:0] pk;
        logic [PACK_W-1:0] junk;
        if (aquire) begin
            check_val("cam_id at aquire", 32'(lines_filled % 2), 32'(cam_id));
            c    = cam_id ? 0 : 1;                    // cam_id 1 is camera 1.
            junk = PACK_W'({$urandom, $urandom});
            if (($urandom % 4) == 0) begin
                pk           = junk;
                pk[FLAG_LSB] = 1'b0;                  // invalid, asked again.
            end else begin
                if (pk_idx[c] == 0) begin
                    new_line(c);
                end
                base = 3 * pk_idx[c];
                col  = base;
                if (bad_col_once && pk_idx[c] == 2) begin
                    col          = base + 1;
                    bad_col_once = 1'b0;
                end
                pk = make_pack(line_row[c], col, {line_bytes[c][base+2],
                     line_bytes[c][base+1], line_bytes[c][base]}, 1'b1);
                pk_idx[c] = pk_idx[c] + 1;
                if (pk_idx[c] == NPACK) begin
                    pk_idx[c]    = 0;
                    lines_filled = lines_filled + 1;
                    rd_left      = H_ACT;             // drain follows this pack.
                end
            end
            cam1_pack <= (c == 0) ? pk : junk;
            cam2_pack <= (c == 1) ? pk : junk;
        end
    endtask

    task automatic serve_reader();
        if (chk_pending) begin
            if (exp_byte_q.size() == 0) begin
                stop_run("read data arrived with no expected byte left");
            end else begin
                check_val("cam_data", 32'(exp_byte_q[0]), 32'(cam_data));
                check_val("cam_row", 32'(exp_row_q[0]), 32'(cam_row));
                void'(exp_byte_q.pop_front());
                if (exp_byte_q.size() % H_ACT == 0) begin
                    void'(exp_row_q.pop_front());
                end
                chk_pending = 1'b0;
            end
        end
        if (read_en) begin
            check_val("busy while reading", 1, 32'(busy));
            chk_pending = 1'b1;                       // byte shows next cycle.
            rd_left     = rd_left - 1;
        end
        read_en <= (rd_left > 0) && (($urandom % 3) != 0);
    endtask

    task automatic watch_busy();
        if (busy_q && !busy) begin
            check_val("bytes left at busy fall", 0, 32'(exp_byte_q.size()));
            check_val("reads left at busy fall", 0, 32'(rd_left));
        end
        busy_q = busy;
    endtask

    task automatic tick();
        @(posedge rclk);
        serve_reader();
        serve_camera();
        watch_busy();
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // sequence helpers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic wait_busy(input logic level, input int limit, input string what);
        for (int i = 0; i < limit; i++) begin
            if (busy === level) begin
                return;
            end
            tick();
        end
        stop_run({"timeout waiting for busy to ", what});
    endtask

    task automatic wait_reset_release();
        for (int i = 0; i < 20; i++) begin
            if (rstn === 1'b1) begin
                return;
            end
            tick();
        end
        stop_run("reset was never released");
    endtask

    task automatic pulse_trig();
        trig <= 1'b1;
        tick();
        tick();
        trig <= 1'b0;
        tick();
        tick();
    endtask

    task automatic check_reset_state();
        check_val("busy after reset", 0, 32'(busy));
        check_val("aquire after reset", 0, 32'(aquire));
        check_val("error after reset", 0, 32'(error));
        check_val("cnt after reset", 0, 32'(cnt));
    endtask

    // extra pulses land while busy and merge into one more sequence.
    task automatic run_sequence(input int extra_trigs, input bit err_exp);
        int runs;
        runs = (extra_trigs > 0) ? 2 : 1;
        pulse_trig();
        for (int r = 0; r < runs; r++) begin
            wait_busy(1'b1, 40, "rise after a trigger");
            exp_cnt = exp_cnt + 4'd1;
            check_val("cnt", 32'(exp_cnt), 32'(cnt));
            if (r == 0) begin
                for (int k = 0; k < extra_trigs; k++) begin
                    pulse_trig();
                end
            end
            wait_busy(1'b0, 3000, "fall after two lines");
        end
        for (int i = 0; i < 30; i++) begin
            tick();
            check_val("busy after sequence", 0, 32'(busy));
        end
        check_val("error", 32'(err_exp), 32'(error));
    endtask

    initial begin
        trig         <= 1'b0;
        read_en      <= 1'b0;
        rst_req      <= 1'b0;
        cam1_pack    <= '0;
        cam2_pack    <= '0;
        pk_idx[0]    = 0;
        pk_idx[1]    = 0;
        lines_filled = 0;
        rd_left      = 0;
        chk_pending  = 1'b0;
        busy_q       = 1'b0;
        bad_col_once = 1'b0;
        exp_cnt      = '0;
        seed_val     = $urandom(32'hac7a4479);

        wait_reset_release();
        check_reset_state();

        // enough sequences for cnt to wrap.
        for (int n = 0; n < 17; n++) begin
            run_sequence((n == 3) ? 2 : 0, 1'b0);
        end

        bad_col_once = 1'b1;
        run_sequence(0, 1'b1);
        run_sequence(0, 1'b1);                        // still set, sticky.

        rst_req <= 1'b1;
        tick();
        rst_req <= 1'b0;
        tick();
        wait_reset_release();
        exp_cnt = '0;
        check_reset_state();
        run_sequence(0, 1'b0);

        $display("TEST OK");
        $finish;
    end

endmodule : tb_cam_capture

//--- tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
    parameter int half_ns    = 5,
    parameter int rst_cycles = 3
) (
    input  logic rst_req,
    output logic rclk,
    output logic rstn
);

    initial begin
        rclk = 1'b0;
        forever #(half_ns) rclk = ~rclk;
    end

    // low at start and again after each rst_req.
    initial begin
        rstn <= 1'b0;
        forever begin
            repeat (rst_cycles) @(posedge rclk);
            rstn <= 1'b1;
            @(posedge rst_req);
            rstn <= 1'b0;
        end
    end

endmodule : tb_clock

//--- trig_sync.sv
`timescale 1ns/1ps

module trig_sync (
    input  logic rclk,
    input  logic rstn,
    input  logic trig,
    input  logic trig_take,
    output logic trig_pend
);

    logic [2:0] sync_q;   // two sync stages plus one of history.
    logic       rise;

    always_ff @(posedge rclk or negedge rstn) begin
        if (!rstn) begin
            sync_q <= '0;
        end else begin
            sync_q <= {sync_q[1:0], trig};
        end
    end

    assign rise = sync_q[1] & ~sync_q[2];

    // a fresh edge wins over a take in the same cycle.
    always_ff @(posedge rclk or negedge rstn) begin
        if (!rstn) begin
            trig_pend <= 1'b0;
        end else if (rise) begin
            trig_pend <= 1'b1;
        end else if (trig_take) begin
            trig_pend <= 1'b0;
        end
    end

    a_take_pend: assert property (@(posedge rclk) disable iff (!rstn)
        trig_take |-> trig_pend)
        else $error("trig_take without pending trigger");

endmodule : trig_sync
